//--- hdl/vec_macros.svh
`ifndef VEC_MACROS_SVH
`define VEC_MACROS_SVH

// Stream phit geometry
`define VEC_PHIT_W      128
`define VEC_LANES       4
`define VEC_ELEM_W      32
`define VEC_KEEP_W      16

// Vector register file layout
`define VEC_NUM_COL     4   // Columns in the mux chain
`define VEC_VRF_DEPTH   8   // Phits per column

// Per-lane stream FIFOs
`define VEC_FIFO_DEPTH  16

`endif

//--- hdl/vec_pkg.sv
`include "vec_macros.svh"

package vec_pkg;

    // Stream side
    typedef logic [`VEC_PHIT_W-1:0] phit_t;
    typedef logic [`VEC_ELEM_W-1:0] elem_t;
    typedef logic [`VEC_LANES-1:0]  lane_mask_t;  // One valid bit per lane
    typedef logic [`VEC_KEEP_W-1:0] keep_t;

    // Register file addressing
    typedef logic [$clog2(`VEC_VRF_DEPTH)-1:0] vrf_addr_t;
    typedef logic [$clog2(`VEC_NUM_COL)-1:0]   col_sel_t;

    // Stored phits, 0 up to a full file of every column
    typedef logic [$clog2(`VEC_NUM_COL * `VEC_VRF_DEPTH + 1)-1:0] word_cnt_t;

    typedef enum logic [2:0] {
        SEQ_IDLE,
        SEQ_LOAD,
        SEQ_STREAMOUT,
        SEQ_DRAIN,
        SEQ_DONE
    } seq_state_t;

endpackage

//--- hdl/stream_lane_fifo.sv
`timescale 1ns/1ps

module stream_lane_fifo #(
    parameter int WIDTH = 34,
    parameter int DEPTH = 16
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             i_push,
    input  logic             i_pop,
    input  logic [WIDTH-1:0] i_din,
    output logic [WIDTH-1:0] o_dout,
    output logic             o_empty,
    output logic             o_full,
    output logic             o_free_ge3
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    logic [WIDTH-1:0] mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             do_push;
    logic             do_pop;

    assign do_push = i_push && !o_full;
    assign do_pop  = i_pop && !o_empty;

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= i_din;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    assign o_dout     = mem[rd_ptr];  // Fall-through head
    assign o_empty    = (count == '0);
    assign o_full     = (count == CNT_W'(DEPTH));
    assign o_free_ge3 = (count <= CNT_W'(DEPTH - 3));

    // Callers must respect the flags, otherwise lanes slip out of alignment
    a_no_push_full: assert property (@(posedge clk) disable iff (rst) !(i_push && o_full))
        else $error("lane FIFO pushed while full");
    a_no_pop_empty: assert property (@(posedge clk) disable iff (rst) !(i_pop && o_empty))
        else $error("lane FIFO popped while empty");

endmodule

//--- hdl/stream_ingress.sv
`timescale 1ns/1ps
`include "vec_macros.svh"

module stream_ingress (
    input  logic                clk,
    input  logic                rst,
    input  vec_pkg::phit_t      i_tdata,
    input  logic                i_tvalid,
    input  logic                i_tlast,
    input  vec_pkg::keep_t      i_tkeep,
    input  logic                i_accept,
    output logic                o_tready,
    input  logic                i_pop,
    output vec_pkg::phit_t      o_in_data,
    output vec_pkg::lane_mask_t o_in_mask,
    output logic                o_in_last,
    output logic                o_in_empty
);
    import vec_pkg::*;

    localparam int KEEP_PER_LANE = `VEC_KEEP_W / `VEC_LANES;

    lane_mask_t lane_valid;
    lane_mask_t lane_full;
    lane_mask_t lane_empty;
    lane_mask_t lane_last;
    logic       handshake;
    logic       pop;
    logic       pkt_closed;  // tlast taken, hold off until the next arm

    assign o_tready  = i_accept && !pkt_closed && !(|lane_full);
    assign handshake = i_tvalid && o_tready;
    assign pop       = i_pop && !o_in_empty;

    always_ff @(posedge clk) begin
        if (rst) begin
            pkt_closed <= 1'b0;
        end else if (!i_accept) begin
            pkt_closed <= 1'b0;
        end else if (handshake && i_tlast) begin
            pkt_closed <= 1'b1;
        end
    end

    for (genvar l = 0; l < `VEC_LANES; l++) begin : g_lane
        // Lane counts only with its whole element kept
        assign lane_valid[l] = &i_tkeep[l*KEEP_PER_LANE +: KEEP_PER_LANE];

        stream_lane_fifo #(
            .WIDTH(`VEC_ELEM_W + 2),
            .DEPTH(`VEC_FIFO_DEPTH)
        ) u_fifo (
            .clk       (clk),
            .rst       (rst),
            .i_push    (handshake),  // All lanes together
            .i_pop     (pop),
            .i_din     ({i_tlast, lane_valid[l], i_tdata[l*`VEC_ELEM_W +: `VEC_ELEM_W]}),
            .o_dout    ({lane_last[l], o_in_mask[l], o_in_data[l*`VEC_ELEM_W +: `VEC_ELEM_W]}),
            .o_empty   (lane_empty[l]),
            .o_full    (lane_full[l]),
            .o_free_ge3()
        );
    end

    assign o_in_empty = |lane_empty;
    assign o_in_last  = &lane_last;

endmodule

//--- hdl/stream_egress.sv
`timescale 1ns/1ps
`include "vec_macros.svh"

module stream_egress (
    input  logic                clk,
    input  logic                rst,
    input  vec_pkg::phit_t      i_push_data,
    input  vec_pkg::lane_mask_t i_push_mask,
    input  logic                i_push_valid,
    input  logic                i_push_last,
    output logic                o_room,
    output logic                o_last_out,
    output vec_pkg::phit_t      o_tdata,
    output logic                o_tvalid,
    input  logic                i_tready,
    output logic                o_tlast,
    output vec_pkg::keep_t      o_tkeep
);
    import vec_pkg::*;

    localparam int KEEP_PER_LANE = `VEC_KEEP_W / `VEC_LANES;

    lane_mask_t lane_empty;
    lane_mask_t lane_free;
    lane_mask_t lane_last;
    lane_mask_t lane_keep;
    logic       pop;

    assign o_tvalid = !(|lane_empty);
    assign pop      = o_tvalid && i_tready;

    for (genvar l = 0; l < `VEC_LANES; l++) begin : g_lane
        stream_lane_fifo #(
            .WIDTH(`VEC_ELEM_W + 2),
            .DEPTH(`VEC_FIFO_DEPTH)
        ) u_fifo (
            .clk       (clk),
            .rst       (rst),
            .i_push    (i_push_valid),
            .i_pop     (pop),
            .i_din     ({i_push_last, i_push_mask[l],
                         i_push_data[l*`VEC_ELEM_W +: `VEC_ELEM_W]}),
            .o_dout    ({lane_last[l], lane_keep[l], o_tdata[l*`VEC_ELEM_W +: `VEC_ELEM_W]}),
            .o_empty   (lane_empty[l]),
            .o_full    (),
            .o_free_ge3(lane_free[l])
        );

        // Mask bit widens back to a keep nibble
        assign o_tkeep[l*KEEP_PER_LANE +: KEEP_PER_LANE] = {KEEP_PER_LANE{lane_keep[l]}};
    end

    // Three slots absorb the reads already in the chain
    assign o_room = &lane_free;

    assign o_tlast    = o_tvalid && (&lane_last);
    assign o_last_out = pop && o_tlast;

endmodule

//--- hdl/vector_column.sv
`timescale 1ns/1ps
`include "vec_macros.svh"

module vector_column #(
    parameter vec_pkg::col_sel_t COL_IDX = '0
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                i_wr_en,
    input  vec_pkg::col_sel_t   i_wr_col,
    input  vec_pkg::vrf_addr_t  i_wr_addr,
    input  vec_pkg::phit_t      i_wr_data,
    input  vec_pkg::lane_mask_t i_wr_mask,
    input  logic                i_rd_en,
    input  vec_pkg::col_sel_t   i_rd_col,
    input  vec_pkg::vrf_addr_t  i_rd_addr,
    input  logic                i_rd_last,
    input  vec_pkg::phit_t      i_up_data,
    input  vec_pkg::lane_mask_t i_up_mask,
    input  logic                i_up_valid,
    input  logic                i_up_last,
    output vec_pkg::phit_t      o_dn_data,
    output vec_pkg::lane_mask_t o_dn_mask,
    output logic                o_dn_valid,
    output logic                o_dn_last
);
    import vec_pkg::*;

    elem_t [`VEC_LANES-1:0] data_mem [`VEC_VRF_DEPTH];
    lane_mask_t             mask_mem [`VEC_VRF_DEPTH];

    logic       wr_hit;
    logic       rd_hit;
    phit_t      rd_data;
    lane_mask_t rd_mask;
    logic       rd_valid;
    logic       rd_last;

    assign wr_hit = i_wr_en && (i_wr_col == COL_IDX);
    assign rd_hit = i_rd_en && (i_rd_col == COL_IDX);

    // Only kept lanes update their element, the mask is always rewritten
    always_ff @(posedge clk) begin
        if (wr_hit) begin
            mask_mem[i_wr_addr] <= i_wr_mask;
            for (int l = 0; l < `VEC_LANES; l++) begin
                if (i_wr_mask[l]) begin
                    data_mem[i_wr_addr][l] <= i_wr_data[l*`VEC_ELEM_W +: `VEC_ELEM_W];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rd_hit) begin
            rd_data <= data_mem[i_rd_addr];
            rd_mask <= mask_mem[i_rd_addr];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_valid <= 1'b0;
            rd_last  <= 1'b0;
        end else begin
            rd_valid <= rd_hit;
            rd_last  <= rd_hit && i_rd_last;
        end
    end

    // Supplier drives its own read, otherwise pass upstream along
    assign o_dn_data  = rd_valid ? rd_data : i_up_data;
    assign o_dn_mask  = rd_valid ? rd_mask : i_up_mask;
    assign o_dn_valid = rd_valid || i_up_valid;
    assign o_dn_last  = rd_valid ? rd_last : i_up_last;

    a_no_chain_collision: assert property (@(posedge clk) disable iff (rst)
        !(rd_valid && i_up_valid))
        else $error("column %0d read collides with upstream phit", COL_IDX);

endmodule

//--- hdl/stream_sequencer.sv
`timescale 1ns/1ps
`include "vec_macros.svh"

module stream_sequencer (
    input  logic                clk,
    input  logic                rst,
    input  logic                i_done_loader,
    input  logic                i_in_empty,
    input  logic                i_in_last,
    input  vec_pkg::phit_t      i_in_data,
    input  vec_pkg::lane_mask_t i_in_mask,
    output logic                o_pop,
    output logic                o_accept,
    output logic                o_wr_en,
    output vec_pkg::col_sel_t   o_wr_col,
    output vec_pkg::vrf_addr_t  o_wr_addr,
    output vec_pkg::phit_t      o_wr_data,
    output vec_pkg::lane_mask_t o_wr_mask,
    output logic                o_rd_en,
    output vec_pkg::col_sel_t   o_rd_col,
    output vec_pkg::vrf_addr_t  o_rd_addr,
    output logic                o_rd_last,
    input  logic                i_room,
    input  logic                i_last_out,
    output logic                o_ap_done
);
    import vec_pkg::*;

    localparam int        ADDR_W    = $bits(vrf_addr_t);
    localparam word_cnt_t MAX_WORDS = word_cnt_t'(`VEC_NUM_COL * `VEC_VRF_DEPTH);

    seq_state_t state;
    seq_state_t state_nxt;
    word_cnt_t  wr_cnt;  // Phits stored so far
    word_cnt_t  rd_cnt;  // Reads issued so far

    always_comb begin
        state_nxt = state;
        case (state)
            SEQ_IDLE:      if (i_done_loader) state_nxt = SEQ_LOAD;
            SEQ_LOAD:      if (o_pop && i_in_last) state_nxt = SEQ_STREAMOUT;
            SEQ_STREAMOUT: if (o_rd_en && o_rd_last) state_nxt = SEQ_DRAIN;
            SEQ_DRAIN:     if (i_last_out) state_nxt = SEQ_DONE;
            SEQ_DONE:      state_nxt = SEQ_IDLE;
            default:       state_nxt = SEQ_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state  <= SEQ_IDLE;
            wr_cnt <= '0;
            rd_cnt <= '0;
        end else begin
            state <= state_nxt;
            if (state == SEQ_IDLE) begin
                wr_cnt <= '0;
                rd_cnt <= '0;
            end
            if (o_wr_en) begin
                wr_cnt <= wr_cnt + 1'b1;
            end
            if (o_rd_en) begin
                rd_cnt <= rd_cnt + 1'b1;
            end
        end
    end

    // One phit per cycle straight from the FIFO heads
    assign o_accept  = (state == SEQ_LOAD);
    assign o_pop     = o_accept && !i_in_empty;
    assign o_wr_en   = o_pop;
    assign o_wr_addr = vrf_addr_t'(wr_cnt);               // Column-major
    assign o_wr_col  = col_sel_t'(wr_cnt >> ADDR_W);
    assign o_wr_data = i_in_data;
    assign o_wr_mask = i_in_mask;

    // Streamout reads back in the same order
    assign o_rd_en   = (state == SEQ_STREAMOUT) && i_room;
    assign o_rd_addr = vrf_addr_t'(rd_cnt);
    assign o_rd_col  = col_sel_t'(rd_cnt >> ADDR_W);
    assign o_rd_last = (rd_cnt == word_cnt_t'(wr_cnt - 1'b1));

    assign o_ap_done = (state == SEQ_DONE);

    // Packet longer than the register files
    a_count_in_range: assert property (@(posedge clk) disable iff (rst)
        o_wr_en |-> (wr_cnt < MAX_WORDS))
        else $error("packet exceeds %0d phits", MAX_WORDS);

endmodule

//--- hdl/vec_data_path.sv
`timescale 1ns/1ps
`include "vec_macros.svh"

module vec_data_path (
    input  logic           clk,
    input  logic           rst,
    input  logic           i_done_loader,
    output logic           o_ap_done,
    // Stream in
    input  vec_pkg::phit_t i_tdata,
    input  logic           i_tvalid,
    output logic           o_tready,
    input  logic           i_tlast,
    input  vec_pkg::keep_t i_tkeep,
    // Stream out
    output vec_pkg::phit_t o_tdata,
    output logic           o_tvalid,
    input  logic           i_tready,
    output logic           o_tlast,
    output vec_pkg::keep_t o_tkeep
);
    import vec_pkg::*;

    phit_t      in_data;
    lane_mask_t in_mask;
    logic       in_last;
    logic       in_empty;
    logic       pop;
    logic       accept;

    logic       wr_en;
    col_sel_t   wr_col;
    vrf_addr_t  wr_addr;
    phit_t      wr_data;
    lane_mask_t wr_mask;
    logic       rd_en;
    col_sel_t   rd_col;
    vrf_addr_t  rd_addr;
    logic       rd_last;

    logic       room;
    logic       last_out;

    // Mux chain, entry 0 is the idle head
    phit_t      chain_data  [`VEC_NUM_COL+1];
    lane_mask_t chain_mask  [`VEC_NUM_COL+1];
    logic       chain_valid [`VEC_NUM_COL+1];
    logic       chain_last  [`VEC_NUM_COL+1];

    assign chain_data[0]  = '0;
    assign chain_mask[0]  = '0;
    assign chain_valid[0] = 1'b0;
    assign chain_last[0]  = 1'b0;

    stream_ingress u_ingress (
        .clk(clk), .rst(rst),
        .i_tdata(i_tdata), .i_tvalid(i_tvalid), .i_tlast(i_tlast), .i_tkeep(i_tkeep),
        .i_accept(accept), .o_tready(o_tready),
        .i_pop(pop), .o_in_data(in_data), .o_in_mask(in_mask),
        .o_in_last(in_last), .o_in_empty(in_empty)
    );

    stream_sequencer u_seq (
        .clk(clk), .rst(rst),
        .i_done_loader(i_done_loader),
        .i_in_empty(in_empty), .i_in_last(in_last), .i_in_data(in_data), .i_in_mask(in_mask),
        .o_pop(pop), .o_accept(accept),
        .o_wr_en(wr_en), .o_wr_col(wr_col), .o_wr_addr(wr_addr),
        .o_wr_data(wr_data), .o_wr_mask(wr_mask),
        .o_rd_en(rd_en), .o_rd_col(rd_col), .o_rd_addr(rd_addr), .o_rd_last(rd_last),
        .i_room(room), .i_last_out(last_out), .o_ap_done(o_ap_done)
    );

    for (genvar c = 0; c < `VEC_NUM_COL; c++) begin : g_col
        vector_column #(
            .COL_IDX(col_sel_t'(c))
        ) u_col (
            .clk(clk), .rst(rst),
            .i_wr_en(wr_en), .i_wr_col(wr_col), .i_wr_addr(wr_addr),
            .i_wr_data(wr_data), .i_wr_mask(wr_mask),
            .i_rd_en(rd_en), .i_rd_col(rd_col), .i_rd_addr(rd_addr), .i_rd_last(rd_last),
            .i_up_data(chain_data[c]), .i_up_mask(chain_mask[c]),
            .i_up_valid(chain_valid[c]), .i_up_last(chain_last[c]),
            .o_dn_data(chain_data[c+1]), .o_dn_mask(chain_mask[c+1]),
            .o_dn_valid(chain_valid[c+1]), .o_dn_last(chain_last[c+1])
        );
    end

    stream_egress u_egress (
        .clk(clk), .rst(rst),
        .i_push_data(chain_data[`VEC_NUM_COL]), .i_push_mask(chain_mask[`VEC_NUM_COL]),
        .i_push_valid(chain_valid[`VEC_NUM_COL]), .i_push_last(chain_last[`VEC_NUM_COL]),
        .o_room(room), .o_last_out(last_out),
        .o_tdata(o_tdata), .o_tvalid(o_tvalid), .i_tready(i_tready),
        .o_tlast(o_tlast), .o_tkeep(o_tkeep)
    );

endmodule

//--- test/tb_vec_data_path.sv
`timescale 1ns/1ps
`include "vec_macros.svh"

module tb_vec_data_path;
    import vec_pkg::*;

    localparam int KPL         = `VEC_KEEP_W / `VEC_LANES;
    localparam int TOTAL_PHITS = 3 + 32 + 20 + 24 + 5 + 6;
    localparam int CYCLE_LIMIT = 40 * TOTAL_PHITS + 2000;

    logic  clk = 1'b0;
    logic  rst;
    logic  i_done_loader;
    logic  o_ap_done;
    phit_t i_tdata;
    logic  i_tvalid;
    logic  o_tready;
    logic  i_tlast;
    keep_t i_tkeep;
    phit_t o_tdata;
    logic  o_tvalid;
    logic  i_tready;
    logic  o_tlast;
    keep_t o_tkeep;

    int          seed = 75707;
    int          ready_seed;
    logic [31:0] ready_rnd;
    logic        rand_ready;
    string       test_name;
    int          stim_errors;
    int          mon_errors = 0;
    int          done_count = 0;
    int          cycles = 0;
    logic        tlast_prev = 1'b0;

    // Expected output filled from accepted input phits
    phit_t exp_data_q [$];
    keep_t exp_keep_q [$];
    logic  exp_last_q [$];
    phit_t ref_data;
    keep_t ref_keep;
    phit_t want_data;
    keep_t want_keep;
    logic  want_last;

    vec_data_path i_dut (
        .clk(clk), .rst(rst),
        .i_done_loader(i_done_loader), .o_ap_done(o_ap_done),
        .i_tdata(i_tdata), .i_tvalid(i_tvalid), .o_tready(o_tready),
        .i_tlast(i_tlast), .i_tkeep(i_tkeep),
        .o_tdata(o_tdata), .o_tvalid(o_tvalid), .i_tready(i_tready),
        .o_tlast(o_tlast), .o_tkeep(o_tkeep)
    );

    always #4 clk = ~clk;

    // A lane survives only with its full keep nibble
    function automatic void expected_phit(input phit_t d, input keep_t k,
                                          output phit_t exp_d, output keep_t exp_k);
        logic kept;
        exp_d = '0;
        exp_k = '0;
        for (int l = 0; l < `VEC_LANES; l++) begin
            kept = &k[l*KPL +: KPL];
            if (kept) begin
                exp_k[l*KPL +: KPL] = '1;
                exp_d[l*`VEC_ELEM_W +: `VEC_ELEM_W] = d[l*`VEC_ELEM_W +: `VEC_ELEM_W];
            end
        end
    endfunction

    function automatic phit_t keep_to_bits(input keep_t k);
        phit_t m;
        for (int b = 0; b < `VEC_KEEP_W; b++) begin
            m[b*8 +: 8] = {8{k[b]}};
        end
        return m;
    endfunction

    // Output ready is random only during the back-pressure test
    initial begin
        i_tready = 1'b1;
        ready_seed = seed + 1;
        forever begin
            @(posedge clk);
            #1;
            ready_rnd = $random(ready_seed);
            i_tready = rand_ready ? (ready_rnd[1:0] == 2'd0) : 1'b1;  // One cycle in four
        end
    end

    always @(negedge clk) begin
        if (!rst) begin
            if (i_tvalid && o_tready) begin
                expected_phit(i_tdata, i_tkeep, ref_data, ref_keep);
                exp_data_q.push_back(ref_data);
                exp_keep_q.push_back(ref_keep);
                exp_last_q.push_back(i_tlast);
            end
            if (o_ap_done) begin
                assert (tlast_prev) else begin
                    mon_errors++;
                    $display("Error: %s ap_done not one cycle after the tlast phit", test_name);
                end
                done_count++;
            end
            tlast_prev = 1'b0;
            if (o_tvalid && i_tready) begin
                assert (exp_data_q.size() > 0) else begin
                    mon_errors++;
                    $display("Error: %s output phit arrived with none expected", test_name);
                end
                if (exp_data_q.size() > 0) begin
                    want_data = exp_data_q.pop_front();
                    want_keep = exp_keep_q.pop_front();
                    want_last = exp_last_q.pop_front();
                    assert (o_tkeep == want_keep) else begin
                        mon_errors++;
                        $display("Fail %s tkeep expected %h actual %h",
                                 test_name, want_keep, o_tkeep);
                    end
                    assert ((o_tdata & keep_to_bits(want_keep)) == want_data) else begin
                        mon_errors++;
                        $display("Fail %s tdata expected %h actual %h",
                                 test_name, want_data, o_tdata & keep_to_bits(want_keep));
                    end
                    assert (o_tlast == want_last) else begin
                        mon_errors++;
                        $display("Fail %s tlast expected %b actual %b",
                                 test_name, want_last, o_tlast);
                    end
                end
                tlast_prev = o_tlast;
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Error: timeout after %0d cycles in %s", cycles, test_name);
            $display("Errors: %0d (stimulus %0d, monitor %0d)",
                     stim_errors + mon_errors + 1, stim_errors + 1, mon_errors);
            $display("TEST FAILED");
            $finish;
        end
    end

    // Offer a phit while idle and expect nothing taken or sent
    task automatic check_not_armed(input int n);
        begin
            i_tvalid = 1'b1;
            i_tdata = '1;
            i_tkeep = '1;
            i_tlast = 1'b0;
            repeat (n) begin
                @(negedge clk);
                assert (!o_tready) else begin
                    stim_errors++;
                    $display("Error: %s o_tready high before the loader strobe", test_name);
                end
                assert (!o_tvalid && !o_tlast && !o_ap_done) else begin
                    stim_errors++;
                    $display("Error: %s output active while idle", test_name);
                end
            end
            @(posedge clk);
            #1;
            i_tvalid = 1'b0;
        end
    endtask

    task automatic arm();
        begin
            i_done_loader = 1'b1;
            @(posedge clk);
            #1;
            i_done_loader = 1'b0;
        end
    endtask

    task automatic send_packet(input int n, input bit rand_keep);
        phit_t       d;
        keep_t       k;
        logic [31:0] r;
        begin
            for (int i = 0; i < n; i++) begin
                d = {$random(seed), $random(seed), $random(seed), $random(seed)};
                k = '1;
                if (rand_keep) begin
                    for (int l = 0; l < `VEC_LANES; l++) begin
                        r = $random(seed);
                        case (r[1:0])
                            2'd0:    k[l*KPL +: KPL] = 4'h0;
                            2'd1:    k[l*KPL +: KPL] = r[7:4];  // Usually partial
                            default: k[l*KPL +: KPL] = 4'hf;
                        endcase
                    end
                end
                i_tdata = d;
                i_tkeep = k;
                i_tlast = (i == n - 1);
                i_tvalid = 1'b1;
                @(negedge clk);
                while (!o_tready) @(negedge clk);
                @(posedge clk);
                #1;
            end
            i_tvalid = 1'b0;
            i_tlast = 1'b0;
        end
    endtask

    // A stray phit stays offered until ap_done and must never be taken
    task automatic wait_done(input int n);
        begin
            i_tvalid = 1'b1;
            i_tdata = '1;
            i_tkeep = '1;
            while (done_count < n) begin
                @(negedge clk);
                assert (!o_tready) else begin
                    stim_errors++;
                    $display("Error: %s o_tready high after the packet's tlast", test_name);
                end
            end
            @(posedge clk);
            #1;
            i_tvalid = 1'b0;
            assert (exp_data_q.size() == 0) else begin
                stim_errors++;
                $display("Error: %s %0d phits never came out", test_name, exp_data_q.size());
            end
        end
    endtask

    initial begin
        rst = 1'b1;
        i_done_loader = 1'b0;
        i_tvalid = 1'b0;
        i_tlast = 1'b0;
        i_tdata = '0;
        i_tkeep = '0;
        rand_ready = 1'b0;
        stim_errors = 0;
        test_name = "reset";
        repeat (8) @(posedge clk);
        #1;
        rst = 1'b0;

        test_name = "basic";
        check_not_armed(10);
        arm();
        send_packet(3, 1'b0);
        wait_done(1);

        test_name = "full_packet";
        arm();
        send_packet(32, 1'b0);  // Fills all four columns
        wait_done(2);

        test_name = "partial_keep";
        arm();
        send_packet(20, 1'b1);
        wait_done(3);

        test_name = "backpressure";
        rand_ready = 1'b1;
        arm();
        send_packet(24, 1'b1);
        wait_done(4);
        rand_ready = 1'b0;

        test_name = "rearm";
        check_not_armed(10);
        arm();
        send_packet(5, 1'b0);
        wait_done(5);
        check_not_armed(6);
        arm();
        send_packet(6, 1'b1);
        wait_done(6);

        repeat (20) @(posedge clk);
        assert (done_count == 6) else begin
            stim_errors++;
            $display("Error: ap_done pulsed %0d times for 6 packets", done_count);
        end

        $display("Errors: %0d (stimulus %0d, monitor %0d)",
                 stim_errors + mon_errors, stim_errors, mon_errors);
        if (stim_errors + mon_errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

//--- sim.f
+incdir+hdl
hdl/vec_pkg.sv
hdl/stream_lane_fifo.sv
hdl/stream_ingress.sv
hdl/stream_egress.sv
hdl/vector_column.sv
hdl/stream_sequencer.sv
hdl/vec_data_path.sv
test/tb_vec_data_path.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the vec_data_path testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    -f sim.f \
    --top-module tb_vec_data_path \
    -o tb_sim

./obj_dir/tb_sim > sim.log 2>&1
cat sim.log

if grep -q "TEST FAILED" sim.log; then
    echo "Simulation reported a failure"
    exit 1
fi

if ! grep -q "TEST PASSED" sim.log; then
    echo "Simulation ended without a result line"
    exit 1
fi

echo "Simulation passed"
